//--- src/axi_mem_pkg.sv
`default_nettype none

package axi_mem_pkg;

  localparam int DATA_W      = 32;
  localparam int STRB_W      = DATA_W / 8;
  localparam int ID_W        = 8;
  localparam int MEM_KB      = 4;
  localparam int LEN_W       = 8;
  localparam int OFFSET_W    = $clog2(STRB_W);                 // Byte lane bits of an address
  localparam int WORD_ADDR_W = $clog2(MEM_KB * 1024 / STRB_W);
  localparam int MEM_WORDS   = 1 << WORD_ADDR_W;

  typedef logic [DATA_W-1:0]      data_t;
  typedef logic [STRB_W-1:0]      strb_t;
  typedef logic [ID_W-1:0]        id_t;
  typedef logic [31:0]            axi_addr_t;
  typedef logic [WORD_ADDR_W-1:0] word_addr_t;
  typedef logic [LEN_W-1:0]       len_t;
  typedef logic [1:0]             resp_t;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_t;

  localparam resp_t RESP_OKAY = 2'b00;

  typedef struct packed {
    id_t        awid;
    axi_addr_t  awaddr;
    len_t       awlen;
    logic [2:0] awsize;
    burst_t     awburst;
    logic       awlock;
    logic [3:0] awcache;
    logic [2:0] awprot;
    logic       awvalid;
    data_t      wdata;
    strb_t      wstrb;
    logic       wlast;
    logic       wvalid;
    logic       bready;
    id_t        arid;
    axi_addr_t  araddr;
    len_t       arlen;
    logic [2:0] arsize;
    burst_t     arburst;
    logic       arlock;
    logic [3:0] arcache;
    logic [2:0] arprot;
    logic       arvalid;
    logic       rready;
  } axi_mosi_t;

  typedef struct packed {
    logic  awready;
    logic  wready;
    id_t   bid;
    resp_t bresp;
    logic  bvalid;
    logic  arready;
    id_t   rid;
    data_t rdata;
    resp_t rresp;
    logic  rlast;
    logic  rvalid;
  } axi_miso_t;

  typedef struct packed {
    logic       en;
    word_addr_t addr;
    data_t      data;
    strb_t      strb;
  } mem_wr_t;

  typedef struct packed {
    logic       en;
    word_addr_t addr;
  } mem_rd_t;

  // Word address of the following beat
  function automatic word_addr_t next_word_addr(word_addr_t addr, burst_t burst);
    word_addr_t nxt;
    case (burst)
      BURST_FIXED: nxt = addr;
      BURST_INCR,
      BURST_WRAP:  nxt = addr + 1;   // WRAP runs as INCR
      default:     nxt = addr + 1;
    endcase
    return nxt;
  endfunction

endpackage

`default_nettype wire

//--- src/sram_bytes.sv
`timescale 1ns/1ps
`default_nettype none

module sram_bytes import axi_mem_pkg::*; (
  input  logic    clk,
  input  mem_wr_t wr,
  input  mem_rd_t rd,
  output data_t   rdata
);

  data_t mem [MEM_WORDS];

  // Byte-enabled write port
  always_ff @(posedge clk) begin
    if (wr.en) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wr.strb[b]) begin
          mem[wr.addr][8*b +: 8] <= wr.data[8*b +: 8];
        end
      end
    end
  end

  // Registered read, old data on a same-cycle write
  always_ff @(posedge clk) begin
    if (rd.en) begin
      rdata <= mem[rd.addr];
    end
  end

endmodule

`default_nettype wire

//--- src/axi_write_burst.sv
`timescale 1ns/1ps
`default_nettype none

module axi_write_burst import axi_mem_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  axi_mosi_t aw_in,
  output logic      awready,
  output logic      wready,
  output id_t       bid,
  output resp_t     bresp,
  output logic      bvalid,
  output mem_wr_t   mem_wr
);

  typedef enum logic [1:0] {
    W_IDLE,
    W_DATA,
    W_RESP
  } wr_state_t;

  wr_state_t  state;
  wr_state_t  state_nxt;

  id_t        id_q;
  word_addr_t addr_q;     // Word of the current beat
  burst_t     burst_q;
  len_t       len_q;
  len_t       cnt_q;      // Beats already written

  logic       aw_fire;
  logic       w_fire;
  logic       b_fire;
  logic       last_beat;

  assign aw_fire   = aw_in.awvalid && awready;
  assign w_fire    = aw_in.wvalid && wready;
  assign b_fire    = bvalid && aw_in.bready;
  assign last_beat = (cnt_q == len_q);

  always_comb begin
    state_nxt = state;
    case (state)
      W_IDLE:  if (aw_fire) state_nxt = W_DATA;
      W_DATA:  if (w_fire && last_beat) state_nxt = W_RESP;  // wlast is not needed here
      W_RESP:  if (b_fire) state_nxt = W_IDLE;
      default: state_nxt = W_IDLE;
    endcase
  end

  // Handshake outputs follow the next state, so they are registered
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= W_IDLE;
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      cnt_q   <= '0;
    end else begin
      state   <= state_nxt;
      awready <= (state_nxt == W_IDLE);
      wready  <= (state_nxt == W_DATA);
      bvalid  <= (state_nxt == W_RESP);
      if (aw_fire) begin
        cnt_q <= '0;
      end else if (w_fire) begin
        cnt_q <= cnt_q + 1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      id_q    <= aw_in.awid;
      addr_q  <= aw_in.awaddr[OFFSET_W +: WORD_ADDR_W];  // Upper bits dropped
      burst_q <= aw_in.awburst;
      len_q   <= aw_in.awlen;
    end else if (w_fire) begin
      addr_q  <= next_word_addr(addr_q, burst_q);
    end
  end

  // Memory is written on the W handshake edge itself
  assign mem_wr = '{en: w_fire, addr: addr_q, data: aw_in.wdata, strb: aw_in.wstrb};

  assign bid   = id_q;
  assign bresp = RESP_OKAY;

endmodule

`default_nettype wire

//--- src/axi_read_burst.sv
`timescale 1ns/1ps
`default_nettype none

module axi_read_burst import axi_mem_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  axi_mosi_t ar_in,
  output logic      arready,
  output id_t       rid,
  output data_t     rdata,
  output resp_t     rresp,
  output logic      rlast,
  output logic      rvalid,
  output mem_rd_t   mem_rd,
  input  data_t     mem_rdata
);

  typedef enum logic {
    R_IDLE,
    R_BURST
  } rd_state_t;

  rd_state_t      state;
  rd_state_t      state_nxt;

  id_t            id_q;
  len_t           len_q;
  burst_t         burst_q;
  word_addr_t     addr_q;      // Word of the next read
  logic [LEN_W:0] issue_cnt;   // Reads issued, up to 256
  len_t           sent_cnt;    // Beats accepted by the master
  logic           pend_q;      // Read issued last cycle
  logic           pend_last_q;

  // Two-entry skid buffer
  data_t          buf_data [2];
  logic [1:0]     buf_last;
  logic           wr_ptr;
  logic           rd_ptr;
  logic [1:0]     buf_cnt;

  logic           ar_fire;
  logic           pop;
  logic           more;
  logic           room;
  logic           issue;
  logic [2:0]     fill;
  word_addr_t     cur_addr;
  burst_t         cur_burst;
  logic           cur_last;

  assign ar_fire = ar_in.arvalid && arready;
  assign pop     = rvalid && ar_in.rready;
  assign more    = (issue_cnt <= {1'b0, len_q});
  assign fill    = {1'b0, buf_cnt} + 3'(pend_q) - 3'(pop);
  assign room    = (fill <= 3'd1);  // Leaves space for one more beat in flight

  // First read goes out on the AR handshake itself
  assign issue     = ar_fire || (state == R_BURST && more && room);
  assign cur_addr  = (state == R_IDLE) ? ar_in.araddr[OFFSET_W +: WORD_ADDR_W] : addr_q;
  assign cur_burst = (state == R_IDLE) ? ar_in.arburst : burst_q;
  assign cur_last  = (state == R_IDLE) ? (ar_in.arlen == '0) : (issue_cnt == {1'b0, len_q});

  assign mem_rd = '{en: issue, addr: cur_addr};

  always_comb begin
    state_nxt = state;
    case (state)
      R_IDLE:  if (ar_fire) state_nxt = R_BURST;
      R_BURST: if (pop && sent_cnt == len_q) state_nxt = R_IDLE;
      default: state_nxt = R_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= R_IDLE;
      arready   <= 1'b0;
      pend_q    <= 1'b0;
      wr_ptr    <= 1'b0;
      rd_ptr    <= 1'b0;
      buf_cnt   <= '0;
      issue_cnt <= '0;
      sent_cnt  <= '0;
    end else begin
      state   <= state_nxt;
      arready <= (state_nxt == R_IDLE);
      pend_q  <= issue;
      buf_cnt <= buf_cnt + 2'(pend_q) - 2'(pop);
      if (pend_q) wr_ptr <= ~wr_ptr;
      if (pop) rd_ptr <= ~rd_ptr;
      if (ar_fire) begin
        issue_cnt <= 1;
        sent_cnt  <= '0;
      end else begin
        if (issue) issue_cnt <= issue_cnt + 1;
        if (pop) sent_cnt <= sent_cnt + 1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      id_q    <= ar_in.arid;
      len_q   <= ar_in.arlen;
      burst_q <= ar_in.arburst;
    end
    if (issue) begin
      addr_q      <= next_word_addr(cur_addr, cur_burst);
      pend_last_q <= cur_last;
    end
    if (pend_q) begin
      buf_data[wr_ptr] <= mem_rdata;  // SRAM output is valid now
      buf_last[wr_ptr] <= pend_last_q;
    end
  end

  assign rvalid = (buf_cnt != 2'd0);
  assign rdata  = buf_data[rd_ptr];
  assign rlast  = buf_last[rd_ptr];
  assign rid    = id_q;
  assign rresp  = RESP_OKAY;

endmodule

`default_nettype wire

//--- src/axi_mem_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_wrapper import axi_mem_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  axi_mosi_t axi_mosi,
  output axi_miso_t axi_miso
);

  mem_wr_t mem_wr;
  mem_rd_t mem_rd;
  data_t   mem_rdata;

  // AW, W and B channels
  axi_write_burst u_write (
    .clk     (clk),
    .rst_n   (rst_n),
    .aw_in   (axi_mosi),
    .awready (axi_miso.awready),
    .wready  (axi_miso.wready),
    .bid     (axi_miso.bid),
    .bresp   (axi_miso.bresp),
    .bvalid  (axi_miso.bvalid),
    .mem_wr  (mem_wr)
  );

  // AR and R channels
  axi_read_burst u_read (
    .clk       (clk),
    .rst_n     (rst_n),
    .ar_in     (axi_mosi),
    .arready   (axi_miso.arready),
    .rid       (axi_miso.rid),
    .rdata     (axi_miso.rdata),
    .rresp     (axi_miso.rresp),
    .rlast     (axi_miso.rlast),
    .rvalid    (axi_miso.rvalid),
    .mem_rd    (mem_rd),
    .mem_rdata (mem_rdata)
  );

  sram_bytes u_sram (
    .clk   (clk),
    .wr    (mem_wr),
    .rd    (mem_rd),
    .rdata (mem_rdata)
  );

endmodule

`default_nettype wire

//--- bench/axi_mem_assert.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_assert import axi_mem_pkg::*; (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    addr_ready,   // awready or arready
  input logic                    data_ready,
  input logic                    rsp_valid,
  input logic                    rsp_ready,
  input logic [ID_W+DATA_W+2:0]  rsp_payload,
  input logic                    beat_fire,
  input logic                    beat_last,
  input logic                    beat_end      // Beat counter at the burst length
);

  // Outputs stay low while reset is held
  assert property (@(posedge clk) !rst_n && $past(!rst_n) |->
                   !addr_ready && !data_ready && !rsp_valid)
    else $error("Valid or ready output high during reset");

  assert property (@(posedge clk) disable iff (!rst_n)
                   rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_payload))
    else $error("Response dropped or changed before ready");

  assert property (@(posedge clk) disable iff (!rst_n)
                   beat_fire |-> beat_last == beat_end)
    else $error("Last flag does not match the end of the beat count");

endmodule

bind axi_write_burst axi_mem_assert u_write_assert (
  .clk         (clk),
  .rst_n       (rst_n),
  .addr_ready  (awready),
  .data_ready  (wready),
  .rsp_valid   (bvalid),
  .rsp_ready   (aw_in.bready),
  .rsp_payload ({bid, {DATA_W{1'b0}}, bresp, 1'b0}),
  .beat_fire   (w_fire),
  .beat_last   (aw_in.wlast),
  .beat_end    (last_beat)
);

bind axi_read_burst axi_mem_assert u_read_assert (
  .clk         (clk),
  .rst_n       (rst_n),
  .addr_ready  (arready),
  .data_ready  (1'b0),
  .rsp_valid   (rvalid),
  .rsp_ready   (ar_in.rready),
  .rsp_payload ({rid, rdata, rresp, rlast}),
  .beat_fire   (pop),
  .beat_last   (rlast),
  .beat_end    (sent_cnt == len_q)
);

`default_nettype wire

//--- bench/tb_axi_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem import axi_mem_pkg::*; ();

  localparam int PAT_WORDS  = 2048;
  localparam int MAX_TR     = 64;
  localparam int MAX_BEATS  = 1024;
  localparam int KIND_WRITE = 1;
  localparam int KIND_READ  = 2;
  localparam logic [1:0] OKAY_CODE = 2'b00;   // AXI OKAY response encoding

  logic        clk;
  logic        rst_n;
  axi_mosi_t   axi_mosi;
  axi_miso_t   axi_miso;

  logic [31:0] pat [PAT_WORDS];       // Raw words of the patterns file
  int          tr_kind  [MAX_TR];
  id_t         tr_id    [MAX_TR];
  axi_addr_t   tr_addr  [MAX_TR];
  len_t        tr_len   [MAX_TR];
  burst_t      tr_burst [MAX_TR];
  int          tr_first [MAX_TR];     // Index of the first beat
  data_t       beat_data [MAX_BEATS];
  strb_t       beat_strb [MAX_BEATS];
  int          n_tr;
  int          n_beats;
  int          errors;
  logic        parsed;
  logic [15:0] lfsr;

  axi_mem_wrapper axi_mem_wrapper_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .axi_mosi (axi_mosi),
    .axi_miso (axi_miso)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Fibonacci LFSR on x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [3:0] draw_bits(input int n);
    logic [3:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      v    = {v[2:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    assert (got === exp) else begin
      errors++;
      $display("ERROR %0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic load_patterns();
    int pos;
    int beats;
    $readmemh("bench/axi_mem_patterns.txt", pat);
    pos     = 0;
    n_tr    = 0;
    n_beats = 0;
    while (n_tr < MAX_TR && pos < PAT_WORDS - 5 &&
           (pat[pos] === KIND_WRITE || pat[pos] === KIND_READ)) begin
      tr_kind[n_tr]  = int'(pat[pos]);
      tr_id[n_tr]    = pat[pos+1][ID_W-1:0];
      tr_addr[n_tr]  = pat[pos+2];
      tr_len[n_tr]   = pat[pos+3][LEN_W-1:0];
      tr_burst[n_tr] = burst_t'(pat[pos+4][1:0]);
      tr_first[n_tr] = n_beats;
      pos  += 5;
      beats = int'(tr_len[n_tr]) + 1;
      for (int b = 0; b < beats; b++) begin
        beat_data[n_beats] = pat[pos];
        pos++;
        if (tr_kind[n_tr] == KIND_WRITE) begin   // Strobe follows each write beat
          beat_strb[n_beats] = pat[pos][STRB_W-1:0];
          pos++;
        end
        n_beats++;
      end
      n_tr++;
    end
  endtask

  task automatic run_write(input int t);
    int   first;
    int   beats;
    logic done;
    first = tr_first[t];
    beats = int'(tr_len[t]) + 1;
    repeat (int'(draw_bits(2))) next_cycle();
    axi_mosi.awid    = tr_id[t];
    axi_mosi.awaddr  = tr_addr[t];
    axi_mosi.awlen   = tr_len[t];
    axi_mosi.awsize  = 3'd2;
    axi_mosi.awburst = tr_burst[t];
    axi_mosi.awvalid = 1'b1;
    do begin
      @(negedge clk);
      done = axi_miso.awready;
      next_cycle();
    end while (!done);
    axi_mosi.awvalid = 1'b0;
    for (int b = 0; b < beats; b++) begin
      repeat (int'(draw_bits(1))) next_cycle();
      axi_mosi.wdata  = beat_data[first + b];
      axi_mosi.wstrb  = beat_strb[first + b];
      axi_mosi.wlast  = (b == beats - 1);
      axi_mosi.wvalid = 1'b1;
      do begin
        @(negedge clk);
        done = axi_miso.wready;
        next_cycle();
      end while (!done);
      axi_mosi.wvalid = 1'b0;
      axi_mosi.wlast  = 1'b0;
    end
    done = 1'b0;
    while (!done) begin
      axi_mosi.bready = (draw_bits(2) != 4'd0);   // Low about one cycle in four
      @(negedge clk);
      if (axi_miso.bvalid && axi_mosi.bready) begin
        done = 1'b1;
        check_value("bid", 32'(tr_id[t]), 32'(axi_miso.bid));
        check_value("bresp", 32'(OKAY_CODE), 32'(axi_miso.bresp));
      end
      next_cycle();
    end
    axi_mosi.bready = 1'b0;
  endtask

  task automatic run_read(input int t);
    int   first;
    int   beats;
    int   got;
    logic done;
    logic seen_last;
    first = tr_first[t];
    beats = int'(tr_len[t]) + 1;
    repeat (int'(draw_bits(2))) next_cycle();
    axi_mosi.arid    = tr_id[t];
    axi_mosi.araddr  = tr_addr[t];
    axi_mosi.arlen   = tr_len[t];
    axi_mosi.arsize  = 3'd2;
    axi_mosi.arburst = tr_burst[t];
    axi_mosi.arvalid = 1'b1;
    do begin
      @(negedge clk);
      done = axi_miso.arready;
      next_cycle();
    end while (!done);
    axi_mosi.arvalid = 1'b0;
    got       = 0;
    seen_last = 1'b0;
    while (!seen_last) begin
      axi_mosi.rready = (draw_bits(2) != 4'd0);
      @(negedge clk);
      if (axi_miso.rvalid && axi_mosi.rready) begin
        assert (got < beats) else begin
          errors++;
          $display("Read burst at %0t returned more beats than its length", $time);
        end
        if (got < beats) begin
          check_value("rdata", beat_data[first + got], axi_miso.rdata);
          check_value("rlast", 32'(got == beats - 1), 32'(axi_miso.rlast));
        end
        check_value("rid", 32'(tr_id[t]), 32'(axi_miso.rid));
        check_value("rresp", 32'(OKAY_CODE), 32'(axi_miso.rresp));
        seen_last = axi_miso.rlast;
        got++;
      end
      next_cycle();
    end
    axi_mosi.rready = 1'b0;
    check_value("R beat count", 32'(beats), 32'(got));
  endtask

  initial begin
    axi_mosi = '0;
    rst_n    = 1'b0;
    errors   = 0;
    parsed   = 1'b0;
    lfsr     = 16'd36783;
    load_patterns();
    parsed = 1'b1;
    assert (n_tr > 0) else begin
      errors++;
      $display("No transactions were read from the patterns file");
    end
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int t = 0; t < n_tr; t++) begin
      if (tr_kind[t] == KIND_WRITE) run_write(t);
      else run_read(t);
    end
    repeat (4) next_cycle();
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Budget of 16 cycles per beat on top of a fixed margin
  initial begin
    int limit;
    wait (parsed);
    limit = n_beats * 16 + 200;
    repeat (limit) @(posedge clk);
    $display("Timeout, the run did not finish within %0d cycles", limit);
    $display("Errors: %0d", errors);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/axi_mem_patterns.txt
// kind (1 write, 2 read), id, addr, len, burst (0 fixed, 1 incr), then per beat
// write beats are data and strobe pairs, read beats are expected data, kind 0 ends the list
1 01 00000000 00 1 11223344 f
2 02 00000000 00 1 11223344
1 03 00000004 00 1 a5a5a5a5 f
2 04 00000004 00 1 a5a5a5a5
1 05 00000000 00 1 ffeeddcc 3
2 06 00000000 00 1 1122ddcc
1 07 00000004 00 1 12345678 9
2 08 00000004 00 1 12a5a578
1 09 00000100 0f 1 10000000 f 10000001 f 10000002 f 10000003 f
  10000004 f 10000005 f 10000006 f 10000007 f 10000008 f 10000009 f
  1000000a f 1000000b f 1000000c f 1000000d f 1000000e f 1000000f f
2 0a 00000100 0f 1 10000000 10000001 10000002 10000003 10000004 10000005
  10000006 10000007 10000008 10000009 1000000a 1000000b 1000000c 1000000d
  1000000e 1000000f
1 0b 00000200 03 0 cafe0000 f cafe0001 f cafe0002 f cafe0003 f
2 0c 00000200 03 0 cafe0003 cafe0003 cafe0003 cafe0003
2 0d 00000110 07 1 10000004 10000005 10000006 10000007 10000008 10000009
  1000000a 1000000b
1 0e 00001008 00 1 deadbeef f
2 0f 00000008 00 1 deadbeef
1 10 0000000c 00 1 0badf00d f
2 11 0000300c 00 1 0badf00d
2 12 fffff000 00 1 1122ddcc
0

//--- compile.f
src/axi_mem_pkg.sv
src/sram_bytes.sv
src/axi_write_burst.sv
src/axi_read_burst.sv
src/axi_mem_wrapper.sv
bench/axi_mem_assert.sv
bench/tb_axi_mem.sv

//--- Makefile
BUILD = obj_dir

.PHONY: all run lint clean

all: run

run:
	verilator --binary --assert --timing -Wno-fatal --top-module tb_axi_mem \
	  -f compile.f --Mdir $(BUILD) -o sim
	$(BUILD)/sim | tee run.log
	@if grep -q "Checks failed" run.log; then exit 1; fi
	@grep -q "All checks passed" run.log

lint:
	verilator --lint-only --assert --timing -Wall --top-module tb_axi_mem -f compile.f

clean:
	rm -rf $(BUILD) run.log
